// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_mem_arb
FILELIST  := sim.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== arb_rr.sv ====
/*
 * Round-robin arbiter with a rotating one-hot priority.
 * The grant and its index are combinational in the request cycle.
 * Priority moves to the slot after the winner only when ena is high.
 */

module arb_rr
#(
    parameter int NUM_CLIENTS = 4
)
(
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             ena,
    input  logic [NUM_CLIENTS-1 : 0]         request,
    output logic [NUM_CLIENTS-1 : 0]         grant,
    output logic [$clog2(NUM_CLIENTS)-1 : 0] grant_idx
);

    localparam int IDX_W = $clog2(NUM_CLIENTS);

    // One-hot slot that currently has the highest priority
    logic [NUM_CLIENTS-1 : 0]   prio;
    // Requests repeated twice so the search can wrap around
    logic [2*NUM_CLIENTS-1 : 0] req_twice;
    logic [2*NUM_CLIENTS-1 : 0] win_twice;
    // Winner folded back to NUM_CLIENTS bits, not gated by ena
    logic [NUM_CLIENTS-1 : 0]   winner;

    // Subtracting the priority clears the lowest request at or above it
    // and the masked result keeps exactly that bit
    assign req_twice = {request, request};
    assign win_twice = req_twice & ~(req_twice - {{NUM_CLIENTS{1'b0}}, prio});
    assign winner    = win_twice[NUM_CLIENTS-1 : 0] |
                       win_twice[2*NUM_CLIENTS-1 : NUM_CLIENTS];

    // The grant needs ena, the index is reported whenever anyone asks
    always_comb
    begin
        grant     = winner & {NUM_CLIENTS{ena}};
        grant_idx = '0;
        for (int i = 0; i < NUM_CLIENTS; i++)
        begin
            if (winner[i])
            begin
                grant_idx = IDX_W'(i);
            end
        end
    end

    // After a real grant the slot following the winner gets priority
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            prio <= {{(NUM_CLIENTS-1){1'b0}}, 1'b1};
        end
        else if (ena && (|request))
        begin
            prio <= {winner[NUM_CLIENTS-2 : 0], winner[NUM_CLIENTS-1]};
        end
    end

endmodule

// ==== client_cmd_fifo.sv ====
/*
 * Per-client command queue.
 * A circular buffer of FIFO_DEPTH commands that shows its oldest entry
 * combinationally and reports a full level to the client.
 */

module client_cmd_fifo
    import mem_arb_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     push,
    input  mem_cmd_t push_cmd,
    input  logic     pop,
    output logic     head_valid,
    output mem_cmd_t head_cmd,
    output logic     full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // Command storage, only the slots between the pointers hold live commands
    mem_cmd_t entries [FIFO_DEPTH];

    // Pointers wrap on their own because the depth is a power of two
    logic [PTR_W-1 : 0] rd_ptr;
    logic [PTR_W-1 : 0] wr_ptr;
    // Occupancy needs one extra bit to tell full from empty
    logic [PTR_W : 0]   count;

    // A push while full is dropped and a pop on empty is ignored
    logic do_push;
    logic do_pop;

    assign head_valid = (count != '0);
    assign full       = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign head_cmd   = entries[rd_ptr];

    assign do_push = push && !full;
    assign do_pop  = pop && head_valid;

    // Payload write into the slot at the write pointer
    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            entries[wr_ptr] <= push_cmd;
        end
    end

    // Pointer and occupancy tracking, push and pop may coincide
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            if (do_push && !do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== cmd_select.sv ====
/*
 * Read/write selector between the two round-robin arbiters.
 * Issues one command per cycle, alternating sides under contention,
 * and pops the winning client's queue.
 */

module cmd_select
    import mem_arb_pkg::*;
#(
    parameter int NUM_CLIENTS = 4
)
(
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             rd_any,
    input  logic [$clog2(NUM_CLIENTS)-1 : 0] rd_idx,
    input  logic                             wr_any,
    input  logic [$clog2(NUM_CLIENTS)-1 : 0] wr_idx,
    input  mem_cmd_t                         head_cmd [NUM_CLIENTS],
    output logic                             rd_ena,
    output logic                             wr_ena,
    output logic [NUM_CLIENTS-1 : 0]         pop,
    output logic                             issue_valid,
    output mem_cmd_t                         issue_cmd,
    output logic [$clog2(NUM_CLIENTS)-1 : 0] issue_client
);

    // Side that wins the next time both a read and a write wait
    sel_state_t state;

    logic pick_rd;
    logic pick_wr;
    logic both_waiting;

    assign both_waiting = rd_any && wr_any;

    // A lone side always wins, a tie goes to the preferred side
    assign pick_rd = rd_any && (!wr_any || (state == PREFER_READ));
    assign pick_wr = wr_any && !pick_rd;

    // Only the arbiter whose winner is issued rotates its priority
    assign rd_ena = pick_rd;
    assign wr_ena = pick_wr;

    assign issue_valid  = pick_rd || pick_wr;
    assign issue_client = pick_rd ? rd_idx : wr_idx;
    // Head of the chosen client, meaningful only with issue_valid
    assign issue_cmd    = head_cmd[issue_client];

    // The issued command leaves its queue on the same edge
    always_comb
    begin
        pop = '0;
        if (issue_valid)
        begin
            pop[issue_client] = 1'b1;
        end
    end

    // Flip the preference only when there was a real choice to make
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= PREFER_READ;
        end
        else if (both_waiting)
        begin
            if (pick_rd)
            begin
                state <= PREFER_WRITE;
            end
            else
            begin
                state <= PREFER_READ;
            end
        end
    end

endmodule

// ==== mem_arb_pkg.sv ====
/*
 * Shared definitions for the multi-client memory port.
 * Holds the memory geometry, the opcode and selector-state enums,
 * and the command struct that travels from the clients to the bank.
 */

package mem_arb_pkg;

    // Memory geometry, 64 words of 32 bits
    localparam int ADDR_W = 6;
    localparam int DATA_W = 32;

    // Command opcode carried by every queue entry
    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_t;

    // Which side wins when both a read and a write are waiting
    typedef enum logic
    {
        PREFER_READ  = 1'b0,
        PREFER_WRITE = 1'b1
    } sel_state_t;

    // One client command as it sits in a queue and as it is issued
    typedef struct packed
    {
        // Read or write
        mem_op_t             op;
        // Word address in the bank
        logic [ADDR_W-1 : 0] addr;
        // Write data, ignored for reads
        logic [DATA_W-1 : 0] wdata;
    } mem_cmd_t;

endpackage

// ==== mem_arb_top.sv ====
/*
 * Shared memory port for NUM_CLIENTS clients.
 * Per-client queues feed a read arbiter and a write arbiter side by
 * side, a selector combines their winners into one issue per cycle.
 */

module mem_arb_top
    import mem_arb_pkg::*;
#(
    parameter int NUM_CLIENTS = 4,
    parameter int FIFO_DEPTH  = 4
)
(
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic [NUM_CLIENTS-1 : 0]         cmd_valid,
    input  mem_cmd_t                         cmd [NUM_CLIENTS],
    output logic [NUM_CLIENTS-1 : 0]         cmd_full,
    output logic                             rsp_valid,
    output logic [$clog2(NUM_CLIENTS)-1 : 0] rsp_client,
    output logic [DATA_W-1 : 0]              rsp_data
);

    localparam int IDX_W = $clog2(NUM_CLIENTS);

    // Queue heads, one per client
    logic [NUM_CLIENTS-1 : 0] head_valid;
    mem_cmd_t                 head_cmd [NUM_CLIENTS];
    logic [NUM_CLIENTS-1 : 0] pop;

    // Requests split by the opcode at each queue head
    logic [NUM_CLIENTS-1 : 0] rd_req;
    logic [NUM_CLIENTS-1 : 0] wr_req;
    logic                     rd_any;
    logic                     wr_any;
    logic [IDX_W-1 : 0]       rd_idx;
    logic [IDX_W-1 : 0]       wr_idx;
    logic                     rd_ena;
    logic                     wr_ena;

    // Issue path from the selector to the bank
    logic                     issue_valid;
    mem_cmd_t                 issue_cmd;
    logic [IDX_W-1 : 0]       issue_client;

    for (genvar i = 0; i < NUM_CLIENTS; i++)
    begin : g_client
        client_cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
            .clk        (clk),
            .reset_n    (reset_n),
            .push       (cmd_valid[i]),
            .push_cmd   (cmd[i]),
            .pop        (pop[i]),
            .head_valid (head_valid[i]),
            .head_cmd   (head_cmd[i]),
            .full       (cmd_full[i])
        );

        assign rd_req[i] = head_valid[i] && (head_cmd[i].op == OP_READ);
        assign wr_req[i] = head_valid[i] && (head_cmd[i].op == OP_WRITE);
    end

    assign rd_any = |rd_req;
    assign wr_any = |wr_req;

    // The selector works from the winner index, so the one-hot grants stay open
    arb_rr #(.NUM_CLIENTS(NUM_CLIENTS)) i_rd_arb (
        .clk       (clk),
        .reset_n   (reset_n),
        .ena       (rd_ena),
        .request   (rd_req),
        .grant     (),
        .grant_idx (rd_idx)
    );

    arb_rr #(.NUM_CLIENTS(NUM_CLIENTS)) i_wr_arb (
        .clk       (clk),
        .reset_n   (reset_n),
        .ena       (wr_ena),
        .request   (wr_req),
        .grant     (),
        .grant_idx (wr_idx)
    );

    cmd_select #(.NUM_CLIENTS(NUM_CLIENTS)) i_cmd_select (
        .clk          (clk),
        .reset_n      (reset_n),
        .rd_any       (rd_any),
        .rd_idx       (rd_idx),
        .wr_any       (wr_any),
        .wr_idx       (wr_idx),
        .head_cmd     (head_cmd),
        .rd_ena       (rd_ena),
        .wr_ena       (wr_ena),
        .pop          (pop),
        .issue_valid  (issue_valid),
        .issue_cmd    (issue_cmd),
        .issue_client (issue_client)
    );

    mem_bank #(.NUM_CLIENTS(NUM_CLIENTS)) i_mem_bank (
        .clk          (clk),
        .reset_n      (reset_n),
        .issue_valid  (issue_valid),
        .issue_cmd    (issue_cmd),
        .issue_client (issue_client),
        .rsp_valid    (rsp_valid),
        .rsp_client   (rsp_client),
        .rsp_data     (rsp_data)
    );

endmodule

// ==== mem_bank.sv ====
/*
 * Single-ported memory bank behind the selector.
 * Writes commit at the issue edge, and a read returns its data with
 * the requesting client's index one cycle later.
 */

module mem_bank
    import mem_arb_pkg::*;
#(
    parameter int NUM_CLIENTS = 4
)
(
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             issue_valid,
    input  mem_cmd_t                         issue_cmd,
    input  logic [$clog2(NUM_CLIENTS)-1 : 0] issue_client,
    output logic                             rsp_valid,
    output logic [$clog2(NUM_CLIENTS)-1 : 0] rsp_client,
    output logic [DATA_W-1 : 0]              rsp_data
);

    localparam int NUM_WORDS = 2 ** ADDR_W;

    // Word array, contents are undefined until written
    logic [DATA_W-1 : 0] mem [NUM_WORDS];

    logic is_read;
    logic is_write;

    assign is_read  = issue_valid && (issue_cmd.op == OP_READ);
    assign is_write = issue_valid && (issue_cmd.op == OP_WRITE);

    // Data path: one access per cycle, either a write or a read
    always_ff @(posedge clk)
    begin
        if (is_write)
        begin
            mem[issue_cmd.addr] <= issue_cmd.wdata;
        end
        if (is_read)
        begin
            rsp_data   <= mem[issue_cmd.addr];
            rsp_client <= issue_client;
        end
    end

    // Response strobe lasts exactly one cycle per issued read
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= is_read;
        end
    end

endmodule

// ==== sim.f ====
mem_arb_pkg.sv
arb_rr.sv
client_cmd_fifo.sv
cmd_select.sv
mem_bank.sv
mem_arb_top.sv
tb_mem_arb.sv

// ==== tb_mem_arb.sv ====
/*
 * Directed testbench for the multi-client memory port.
 * Covers reset state, per-client write/read, round-robin order,
 * read/write alternation and random traffic against a word model.
 */

module tb_mem_arb
    import mem_arb_pkg::*;
();

    localparam int NUM_CLIENTS = 4;
    localparam int FIFO_DEPTH  = 4;
    localparam int IDX_W       = $clog2(NUM_CLIENTS);
    localparam int WAIT_LIMIT  = 1000;
    // Each client owns 16 words, the first 16 commands fill them
    localparam int RANGE       = 16;
    localparam int RANDOM_CMDS = 48;

    logic                     clk;
    logic                     reset_n;
    logic [NUM_CLIENTS-1 : 0] cmd_valid;
    mem_cmd_t                 cmd [NUM_CLIENTS];
    logic [NUM_CLIENTS-1 : 0] cmd_full;
    logic                     rsp_valid;
    logic [IDX_W-1 : 0]       rsp_client;
    logic [DATA_W-1 : 0]      rsp_data;

    // Expected memory contents, kept in per-client issue order
    logic [DATA_W-1 : 0] ref_mem [2**ADDR_W];
    // Read data each client still expects, oldest first
    logic [DATA_W-1 : 0] expect_q [NUM_CLIENTS][$];
    // Responses seen by the monitor, with the cycle they showed up in
    logic [IDX_W-1 : 0]  got_client [$];
    logic [DATA_W-1 : 0] got_data [$];
    longint              got_cycle [$];
    longint              cycle_count = 0;

    mem_arb_top #(.NUM_CLIENTS(NUM_CLIENTS), .FIFO_DEPTH(FIFO_DEPTH)) i_mem_arb_top (
        .clk        (clk),
        .reset_n    (reset_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_full   (cmd_full),
        .rsp_valid  (rsp_valid),
        .rsp_client (rsp_client),
        .rsp_data   (rsp_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    // Responses are sampled mid-cycle, well away from the rising edge
    always @(negedge clk)
    begin
        if (reset_n && rsp_valid)
        begin
            got_client.push_back(rsp_client);
            got_data.push_back(rsp_data);
            got_cycle.push_back(cycle_count);
        end
    end

    task automatic report_failure(string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected)
        begin
            report_failure($sformatf("mismatch %s: got 0x%0h, expected 0x%0h",
                                     name, actual, expected));
        end
    endtask

    // Every address bit shows up somewhere in the word
    function automatic logic [DATA_W-1 : 0] fill_word(int addr);
        return 32'h5a3c_0000 ^ (32'(addr) * 32'h0104_1041);
    endfunction

    function automatic mem_cmd_t make_cmd(mem_op_t op, int addr, logic [DATA_W-1 : 0] wdata);
        mem_cmd_t c;
        c.op    = op;
        c.addr  = ADDR_W'(addr);
        c.wdata = wdata;
        return c;
    endfunction

    task automatic apply_reset();
        reset_n   = 1'b0;
        cmd_valid = '0;
        repeat (8) @(negedge clk);
        reset_n = 1'b1;
        got_client.delete();
        got_data.delete();
        got_cycle.delete();
    endtask

    // Holds the staged commands valid for one cycle, starting at a falling edge
    task automatic drive(logic [NUM_CLIENTS-1 : 0] mask);
        cmd_valid = mask;
        @(negedge clk);
        cmd_valid = '0;
    endtask

    // Waits for count responses, then makes sure no stray one follows
    task automatic wait_responses(int count);
        int waited;
        waited = 0;
        while (got_data.size() < count)
        begin
            if (waited == WAIT_LIMIT)
            begin
                report_failure($sformatf("timed out waiting for %0d read responses", count));
            end
            waited++;
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        check_value("response count", 64'(got_data.size()), 64'(count));
    endtask

    task automatic take_response(output int client, output logic [DATA_W-1 : 0] data,
                                 output longint cycle);
        client = int'(got_client.pop_front());
        data   = got_data.pop_front();
        cycle  = got_cycle.pop_front();
    endtask

    task automatic test_reset_state();
        apply_reset();
        check_value("rsp_valid", 64'(rsp_valid), 64'd0);
        check_value("cmd_full", 64'(cmd_full), 64'd0);
    endtask

    // Each client writes a value tagged with its own index, then reads it back
    task automatic test_write_read();
        logic [DATA_W-1 : 0] value;
        logic [DATA_W-1 : 0] data;
        int                  client;
        longint              cycle;
        for (int c = 0; c < NUM_CLIENTS; c++)
        begin
            value = ($urandom() & 32'h00ff_ffff) | (32'(c) << 24);
            ref_mem[c * RANGE] = value;
            cmd[c] = make_cmd(OP_WRITE, c * RANGE, value);
            drive(NUM_CLIENTS'(1 << c));
            cmd[c] = make_cmd(OP_READ, c * RANGE, '0);
            drive(NUM_CLIENTS'(1 << c));
            wait_responses(1);
            take_response(client, data, cycle);
            check_value("rsp_client", 64'(client), 64'(c));
            check_value("rsp_data", 64'(data), 64'(value));
        end
    endtask

    // With priority back at client 0, grants sweep 0 to 3 twice without a gap
    task automatic test_round_robin();
        logic [DATA_W-1 : 0] data;
        int                  client;
        longint              cycle;
        longint              last_cycle;
        apply_reset();
        for (int c = 0; c < NUM_CLIENTS; c++)
        begin
            cmd[c] = make_cmd(OP_READ, c * RANGE, '0);
        end
        drive('1);
        drive('1);
        wait_responses(2 * NUM_CLIENTS);
        last_cycle = 0;
        for (int n = 0; n < 2 * NUM_CLIENTS; n++)
        begin
            take_response(client, data, cycle);
            check_value("rsp_client", 64'(client), 64'(n % NUM_CLIENTS));
            check_value("rsp_data", 64'(data), 64'(ref_mem[(n % NUM_CLIENTS) * RANGE]));
            if (n > 0)
            begin
                check_value("response spacing", 64'(cycle - last_cycle), 64'd1);
            end
            last_cycle = cycle;
        end
    endtask

    // Reads of address 0 from client 0 interleave with writes from client 1,
    // so each read sees the value written just before it
    task automatic test_alternation();
        logic [DATA_W-1 : 0] wval [4];
        logic [DATA_W-1 : 0] data;
        logic [DATA_W-1 : 0] expected;
        int                  client;
        longint              cycle;
        longint              last_cycle;
        apply_reset();
        for (int k = 0; k < 4; k++)
        begin
            wval[k] = $urandom();
            cmd[0]  = make_cmd(OP_READ, 0, '0);
            cmd[1]  = make_cmd(OP_WRITE, 0, wval[k]);
            drive(NUM_CLIENTS'(4'b0011));
        end
        wait_responses(4);
        last_cycle = 0;
        for (int k = 0; k < 4; k++)
        begin
            take_response(client, data, cycle);
            expected = (k == 0) ? ref_mem[0] : wval[k - 1];
            check_value("rsp_client", 64'(client), 64'd0);
            check_value("rsp_data", 64'(data), 64'(expected));
            if (k > 0)
            begin
                check_value("response spacing", 64'(cycle - last_cycle), 64'd2);
            end
            last_cycle = cycle;
        end
        ref_mem[0] = wval[3];
    endtask

    // Clients push whenever their queue has room; expected read data is fixed
    // at push time because a client alone touches its own address range
    task automatic test_random_traffic();
        int                       sent [NUM_CLIENTS];
        int                       total;
        int                       reads;
        int                       addr;
        int                       waited;
        int                       client;
        logic [DATA_W-1 : 0]      value;
        logic [DATA_W-1 : 0]      data;
        logic [NUM_CLIENTS-1 : 0] mask;
        longint                   cycle;
        total  = 0;
        reads  = 0;
        waited = 0;
        foreach (sent[c])
        begin
            sent[c] = 0;
        end
        while (total < NUM_CLIENTS * RANDOM_CMDS)
        begin
            if (waited == WAIT_LIMIT)
            begin
                report_failure("random traffic could not push all of its commands in time");
            end
            mask = '0;
            for (int c = 0; c < NUM_CLIENTS; c++)
            begin
                if (!cmd_full[c] && sent[c] < RANDOM_CMDS)
                begin
                    if (sent[c] < RANGE)
                    begin
                        addr = c * RANGE + sent[c];
                        ref_mem[addr] = fill_word(addr);
                        cmd[c] = make_cmd(OP_WRITE, addr, ref_mem[addr]);
                    end
                    else
                    begin
                        addr = c * RANGE + int'($urandom_range(RANGE - 1, 0));
                        if ($urandom_range(1, 0) == 1)
                        begin
                            value = $urandom();
                            ref_mem[addr] = value;
                            cmd[c] = make_cmd(OP_WRITE, addr, value);
                        end
                        else
                        begin
                            expect_q[c].push_back(ref_mem[addr]);
                            reads++;
                            cmd[c] = make_cmd(OP_READ, addr, '0);
                        end
                    end
                    mask[c] = 1'b1;
                    sent[c]++;
                    total++;
                end
            end
            drive(mask);
            waited++;
        end
        wait_responses(reads);
        for (int n = 0; n < reads; n++)
        begin
            take_response(client, data, cycle);
            if (expect_q[client].size() == 0)
            begin
                report_failure($sformatf("client %0d answered with no read outstanding", client));
            end
            check_value("rsp_data", 64'(data), 64'(expect_q[client].pop_front()));
        end
    endtask

    initial
    begin
        reset_n    = 1'b0;
        cmd_valid  = '0;
        foreach (cmd[c])
        begin
            cmd[c] = '0;
        end
        void'($urandom(32'hff60_4d9f));
        test_reset_state();
        test_write_read();
        test_round_robin();
        test_alternation();
        test_random_traffic();
        $display("TEST PASSED");
        $finish;
    end

    // Last line of defense if a test ever stops advancing
    initial
    begin
        repeat (20000) @(posedge clk);
        report_failure("simulation ran past its overall cycle limit");
    end

endmodule
